/* sim/alu_imm_testdata.txt */
# op imm12 src_PR src_is_zero dest_PR, all hex; op is the alu_op_t encoding
# a line with the word stall holds back issue for the ops after it
0 5a5 00 1 01
0 800 00 1 02
6 123 02 0 03
4 7ff 03 0 04
7 0f0 04 0 05
1 004 01 0 06
5 003 02 0 07
2 fff 02 0 08
3 fff 05 0 09
0 001 09 0 0a
stall
0 010 00 1 0b
1 01f 0a 0 0c
5 001 0c 0 0d
d 41f 02 0 0e
4 555 01 0 0f
6 00f 0f 0 10
7 3c3 07 0 11
2 7ff 06 0 12
3 001 00 1 13
0 fff 13 0 14
d 404 0e 0 15
0 333 00 0 16
7 fff 16 0 17

/* files.f */
verilog/core_pkg.sv
verilog/core_ifs.sv
verilog/alu_imm_iq.sv
verilog/operand_read.sv
verilog/alu_imm_exec.sv
verilog/alu_imm_top.sv
sim/tb_alu_imm.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ALU reg-imm slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_alu_imm -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_alu_imm)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* sim/tb_alu_imm.sv */
`timescale 1ns/1ps

module tb_alu_imm import core_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic                       CLK = 1'b0;
    logic                       nRST;
    logic                       enq_valid;
    alu_op_t                    enq_op;
    logic [11:0]                enq_imm12;
    logic [LOG_PR_COUNT-1:0]    enq_A_PR;
    logic                       enq_A_ready;
    logic                       enq_A_is_zero;
    logic [LOG_PR_COUNT-1:0]    enq_dest_PR;
    logic [LOG_ROB_ENTRIES-1:0] enq_ROB_index;
    logic                       enq_ready;
    logic                       stall;
    logic                       wb_valid;
    logic [LOG_PR_COUNT-1:0]    wb_dest_PR;
    logic [LOG_ROB_ENTRIES-1:0] wb_ROB_index;
    logic [XLEN-1:0]            wb_data;

    // program-order model and scoreboard, indexed by ROB
    logic [XLEN-1:0]         model_regs [PR_COUNT];
    bit                      pending [PR_COUNT];
    logic [XLEN-1:0]         exp_data [ROB_ENTRIES];
    logic [LOG_PR_COUNT-1:0] exp_dest [ROB_ENTRIES];
    bit                      seen [ROB_ENTRIES];
    bit                      ready_at_enq [ROB_ENTRIES];
    int                      wb_cycle [ROB_ENTRIES];
    int                      enq_count = 0;
    int                      wb_count = 0;
    int                      last_ready_rob = -1;
    int                      accept_cycle = 0;
    int                      cycle = 0;
    logic [31:0]             lcg_state = 32'h600;

    alu_imm_top dut (
        .CLK(CLK), .nRST(nRST),
        .enq_valid(enq_valid), .enq_op(enq_op), .enq_imm12(enq_imm12),
        .enq_A_PR(enq_A_PR), .enq_A_ready(enq_A_ready), .enq_A_is_zero(enq_A_is_zero),
        .enq_dest_PR(enq_dest_PR), .enq_ROB_index(enq_ROB_index), .enq_ready(enq_ready),
        .stall(stall),
        .wb_valid(wb_valid), .wb_dest_PR(wb_dest_PR), .wb_ROB_index(wb_ROB_index),
        .wb_data(wb_data)
    );

    always #10 CLK = ~CLK;

    always @(posedge CLK) cycle <= cycle + 1;

    // ------------------------------------------------------------
    // failure reporting and compares

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("ERROR: %s", what);
        stop_run();
    endtask

    task automatic check_wb(input logic [LOG_ROB_ENTRIES-1:0] rob,
                            input logic [LOG_PR_COUNT-1:0] dest, input logic [XLEN-1:0] data);
        if (dest !== exp_dest[rob]) begin
            $display("[FAIL] wb_dest_PR for ROB 0x%h: expected 0x%h, got 0x%h",
                     rob, exp_dest[rob], dest);
            stop_run();
        end
        if (data !== exp_data[rob]) begin
            $display("[FAIL] wb_data for ROB 0x%h: expected 0x%h, got 0x%h",
                     rob, exp_data[rob], data);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ------------------------------------------------------------
    // stimulus helpers, all entered and left 2 ns after a rising edge

    task automatic wait_for_writebacks(input string what);
        int waited;
        waited = 0;
        while (wb_count != enq_count) begin
            if (waited >= TIMEOUT) report_problem({"timed out waiting for ", what});
            @(posedge CLK);
            #2;
            waited++;
        end
    endtask

    // gives up only when stalled and the queue is full
    task automatic enqueue_op(input alu_op_t op, input logic [11:0] imm,
                              input logic [LOG_PR_COUNT-1:0] src, input logic is_zero,
                              input logic [LOG_PR_COUNT-1:0] dest, output bit accepted);
        int              waited;
        bit              gave_up;
        logic [XLEN-1:0] a;
        waited = 0;
        gave_up = 1'b0;
        accepted = 1'b0;
        enq_op = op;
        enq_imm12 = imm;
        enq_A_PR = src;
        enq_A_is_zero = is_zero;
        enq_dest_PR = dest;
        enq_ROB_index = LOG_ROB_ENTRIES'(enq_count);
        enq_valid = 1'b1;
        while (!accepted && !gave_up) begin
            // source counts as ready once its producer has written back
            enq_A_ready = ~pending[src];
            @(negedge CLK);
            if (enq_ready) begin
                accepted = 1'b1;
                accept_cycle = cycle;
                ready_at_enq[enq_count] = enq_A_ready | is_zero;
                pending[dest] = 1'b1;
                a = is_zero ? '0 : model_regs[src];
                exp_data[enq_count] = alu_imm_result(op, a, imm);
                exp_dest[enq_count] = dest;
                model_regs[dest] = exp_data[enq_count];
            end else if (stall) begin
                gave_up = 1'b1;
            end else begin
                waited++;
                if (waited >= TIMEOUT) report_problem("timed out waiting for enq_ready");
            end
            @(posedge CLK);
            #2;
        end
        if (accepted) enq_count++;
        enq_valid = 1'b0;
    endtask

    // ------------------------------------------------------------
    // writeback monitor

    always @(negedge CLK) begin
        int rob;
        if (nRST && wb_valid) begin
            rob = int'(wb_ROB_index);
            if (rob >= enq_count) report_problem("writeback for a ROB index never enqueued");
            if (seen[rob]) report_problem("a ROB index wrote back twice");
            check_wb(wb_ROB_index, wb_dest_PR, wb_data);
            // ops ready at enqueue must leave oldest first
            if (ready_at_enq[rob]) begin
                if (rob < last_ready_rob)
                    report_problem("a ready op wrote back after a younger ready op");
                last_ready_rob = rob;
            end
            seen[rob] = 1'b1;
            wb_cycle[rob] = cycle;
            pending[wb_dest_PR] = 1'b0;
            wb_count++;
        end
    end

    // ------------------------------------------------------------
    // main sequence

    initial begin
        int          fd;
        int          n;
        int          idle;
        int          stall_accepted;
        int          wb_at_stall;
        string       line;
        logic [31:0] op_v, imm_v, src_v, zero_v, dest_v;
        bit          accepted;
        bit          first_op;
        bit          stalled;
        nRST = 1'b0;
        enq_valid = 1'b0;
        enq_op = ADDI;
        enq_imm12 = '0;
        enq_A_PR = '0;
        enq_A_ready = 1'b0;
        enq_A_is_zero = 1'b0;
        enq_dest_PR = '0;
        enq_ROB_index = '0;
        stall = 1'b0;
        first_op = 1'b1;
        stalled = 1'b0;
        stall_accepted = 0;
        wb_at_stall = 0;
        for (int r = 0; r < PR_COUNT; r++) model_regs[r] = '0;
        fd = $fopen("sim/alu_imm_testdata.txt", "r");
        if (fd == 0) report_problem("could not open sim/alu_imm_testdata.txt");
        repeat (10) @(posedge CLK);
        #2;
        nRST = 1'b1;
        @(posedge CLK);
        #2;
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") continue;
            if (line.substr(0, 4) == "stall") begin
                wait_for_writebacks("the pipeline to drain before the stall");
                stall = 1'b1;
                stalled = 1'b1;
                wb_at_stall = wb_count;
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h", op_v, imm_v, src_v, zero_v, dest_v);
            if (n != 5) report_problem({"bad test data line: ", line});
            if (!first_op && !stalled) begin
                lcg_state = lcg_next(lcg_state);
                idle = int'(lcg_state[31:24]) % 3;
                repeat (idle) begin
                    @(posedge CLK);
                    #2;
                end
            end
            enqueue_op(alu_op_t'(op_v[3:0]), imm_v[11:0], src_v[4:0], zero_v[0],
                       dest_v[4:0], accepted);
            if (first_op) begin
                // empty idle queue, ready operand
                wait_for_writebacks("the first writeback");
                check_count("first op latency in cycles", 3, wb_cycle[0] - accept_cycle);
                first_op = 1'b0;
            end
            if (stalled && accepted) begin
                stall_accepted++;
            end else if (stalled) begin
                check_count("ops accepted under stall", IQ_ENTRIES, stall_accepted);
                check_flag("enq_ready", 1'b0, enq_ready);
                repeat (4) begin
                    @(posedge CLK);
                    #2;
                end
                check_count("writebacks under stall", wb_at_stall, wb_count);
                stall = 1'b0;
                stalled = 1'b0;
                enqueue_op(alu_op_t'(op_v[3:0]), imm_v[11:0], src_v[4:0], zero_v[0],
                           dest_v[4:0], accepted);
            end
        end
        $fclose(fd);
        if (stalled) report_problem("test data ended while stall was still held");
        wait_for_writebacks("the last writebacks");
        @(negedge CLK);
        check_flag("wb_valid", 1'b0, wb_valid);
        check_flag("enq_ready", 1'b1, enq_ready);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verilog/alu_imm_top.sv */
`timescale 1ns/1ps

module alu_imm_top import core_pkg::*; (
    input  logic                       CLK,
    input  logic                       nRST,

    input  logic                       enq_valid,
    input  alu_op_t                    enq_op,
    input  logic [11:0]                enq_imm12,
    input  logic [LOG_PR_COUNT-1:0]    enq_A_PR,
    input  logic                       enq_A_ready,
    input  logic                       enq_A_is_zero,
    input  logic [LOG_PR_COUNT-1:0]    enq_dest_PR,
    input  logic [LOG_ROB_ENTRIES-1:0] enq_ROB_index,
    output logic                       enq_ready,

    input  logic                       stall,

    output logic                       wb_valid,
    output logic [LOG_PR_COUNT-1:0]    wb_dest_PR,
    output logic [LOG_ROB_ENTRIES-1:0] wb_ROB_index,
    output logic [XLEN-1:0]            wb_data
);

    issue_if iss ();
    wb_if    wb ();

    logic                       ff_valid;
    logic [LOG_PR_COUNT-1:0]    ff_PR;
    logic                       rd_valid;
    alu_op_t                    rd_op;
    logic [11:0]                rd_imm12;
    logic                       rd_A_sel;
    logic [XLEN-1:0]            rd_A_value;
    logic [LOG_PR_COUNT-1:0]    rd_dest_PR;
    logic [LOG_ROB_ENTRIES-1:0] rd_ROB_index;

    alu_imm_iq u_iq (.*);
    operand_read u_rd (.*);
    alu_imm_exec u_exec (.*);

    assign wb_valid = |wb.valid_by_bank;
    assign wb_dest_PR = wb.dest_PR;
    assign wb_ROB_index = wb.ROB_index;
    assign wb_data = wb.data;

endmodule

/* verilog/alu_imm_exec.sv */
`timescale 1ns/1ps

module alu_imm_exec import core_pkg::*; (
    input  logic                       CLK,
    input  logic                       nRST,

    input  logic                       rd_valid,
    input  alu_op_t                    rd_op,
    input  logic [11:0]                rd_imm12,
    input  logic                       rd_A_sel,
    input  logic [XLEN-1:0]            rd_A_value,
    input  logic [LOG_PR_COUNT-1:0]    rd_dest_PR,
    input  logic [LOG_ROB_ENTRIES-1:0] rd_ROB_index,

    wb_if.exec                         wb
);

    logic                       ex_valid;
    logic [LOG_PR_COUNT-1:0]    ex_dest_PR;
    logic [LOG_ROB_ENTRIES-1:0] ex_ROB_index;
    logic [XLEN-1:0]            ex_data;
    logic [XLEN-1:0]            A_value;

    // fast forward takes our own previous result
    assign A_value = rd_A_sel ? ex_data : rd_A_value;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= rd_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (rd_valid) begin
            ex_dest_PR <= rd_dest_PR;
            ex_ROB_index <= rd_ROB_index;
            ex_data <= alu_imm_result(rd_op, A_value, rd_imm12);
        end
    end

    // ----------------------------------------------------------
    // writeback bus, valid on the destination's bank only

    always_comb begin
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            wb.valid_by_bank[b] = ex_valid
                && ex_dest_PR[LOG_PRF_BANK_COUNT-1:0] == LOG_PRF_BANK_COUNT'(b);
            wb.upper_PR_by_bank[b] = ex_dest_PR[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
        end
    end

    assign wb.data = ex_data;
    assign wb.dest_PR = ex_dest_PR;
    assign wb.ROB_index = ex_ROB_index;

endmodule

/* verilog/operand_read.sv */
`timescale 1ns/1ps

module operand_read import core_pkg::*; (
    input  logic                       CLK,
    input  logic                       nRST,

    issue_if.rd                        iss,
    wb_if.rd                           wb,
    input  logic                       stall,

    // fast forward notification back to the queue
    output logic                       ff_valid,
    output logic [LOG_PR_COUNT-1:0]    ff_PR,

    // read-stage register
    output logic                       rd_valid,
    output alu_op_t                    rd_op,
    output logic [11:0]                rd_imm12,
    output logic                       rd_A_sel,
    output logic [XLEN-1:0]            rd_A_value,
    output logic [LOG_PR_COUNT-1:0]    rd_dest_PR,
    output logic [LOG_ROB_ENTRIES-1:0] rd_ROB_index
);

    // PRF as [bank][index within bank]
    logic [PRF_BANK_COUNT-1:0][PR_COUNT/PRF_BANK_COUNT-1:0][XLEN-1:0] prf;

    logic            fire;
    logic [XLEN-1:0] prf_rd;
    logic [XLEN-1:0] A_value;

    assign iss.ready = ~stall;
    assign fire = iss.valid & iss.ready;

    // ----------------------------------------------------------
    // banked register file

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            prf <= '0;
        end else begin
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                if (wb.valid_by_bank[b]) begin
                    prf[b][wb.upper_PR_by_bank[b]] <= wb.data;
                end
            end
        end
    end

    assign prf_rd = prf[iss.A_PR[LOG_PRF_BANK_COUNT-1:0]]
                       [iss.A_PR[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]];

    // fast forward value comes later, from the execute stage
    always_comb begin
        if (iss.A_is_reg) begin
            A_value = prf_rd;
        end else if (iss.A_is_bus_forward) begin
            A_value = wb.data;
        end else begin
            A_value = '0;
        end
    end

    // ----------------------------------------------------------
    // stage register

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= fire;
        end
    end

    always_ff @(posedge CLK) begin
        if (fire) begin
            rd_op <= iss.op;
            rd_imm12 <= iss.imm12;
            rd_A_sel <= iss.A_is_fast_forward;
            rd_A_value <= A_value;
            rd_dest_PR <= iss.dest_PR;
            rd_ROB_index <= iss.ROB_index;
        end
    end

    assign ff_valid = rd_valid;
    assign ff_PR = rd_dest_PR;

    // register 0 is bank 0, index 0 and must stay zero
    a_no_r0_write: assert property (@(posedge CLK) disable iff (!nRST)
        wb.valid_by_bank[0] |-> wb.upper_PR_by_bank[0] != '0);

endmodule

/* verilog/alu_imm_iq.sv */
`timescale 1ns/1ps

module alu_imm_iq import core_pkg::*; (
    input  logic                       CLK,
    input  logic                       nRST,

    // enqueue
    input  logic                       enq_valid,
    input  alu_op_t                    enq_op,
    input  logic [11:0]                enq_imm12,
    input  logic [LOG_PR_COUNT-1:0]    enq_A_PR,
    input  logic                       enq_A_ready,
    input  logic                       enq_A_is_zero,
    input  logic [LOG_PR_COUNT-1:0]    enq_dest_PR,
    input  logic [LOG_ROB_ENTRIES-1:0] enq_ROB_index,
    output logic                       enq_ready,

    issue_if.iq                        iss,
    wb_if.iq                           wb,

    // op currently in the read stage
    input  logic                       ff_valid,
    input  logic [LOG_PR_COUNT-1:0]    ff_PR
);

    // ----------------------------------------------------------
    // entries, index 0 is the oldest

    logic [IQ_ENTRIES-1:0]                       valid_by_entry;
    logic [IQ_ENTRIES-1:0]                       A_ready_by_entry;
    alu_op_t                                     op_by_entry [IQ_ENTRIES];
    logic [IQ_ENTRIES-1:0][11:0]                 imm12_by_entry;
    logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0]     A_PR_by_entry;
    logic [IQ_ENTRIES-1:0]                       A_is_zero_by_entry;
    logic [IQ_ENTRIES-1:0][LOG_PR_COUNT-1:0]     dest_PR_by_entry;
    logic [IQ_ENTRIES-1:0][LOG_ROB_ENTRIES-1:0]  ROB_index_by_entry;

    // wakeup and select
    logic [IQ_ENTRIES-1:0] bus_match;
    logic [IQ_ENTRIES-1:0] A_is_bus_forward_by_entry;
    logic [IQ_ENTRIES-1:0] A_is_fast_forward_by_entry;
    logic [IQ_ENTRIES-1:0] issue_ready_by_entry;
    logic [IQ_ENTRIES-1:0] issue_one_hot;
    logic [IQ_ENTRIES-1:0] issue_mask;

    // enqueue
    logic [IQ_ENTRIES-1:0] enq_one_hot;
    logic                  enq_bus_match;

    // ----------------------------------------------------------
    // wakeup against the bus and the read stage

    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            bus_match[i] = wb.valid_by_bank[A_PR_by_entry[i][LOG_PRF_BANK_COUNT-1:0]]
                && wb.upper_PR_by_bank[A_PR_by_entry[i][LOG_PRF_BANK_COUNT-1:0]]
                   == A_PR_by_entry[i][LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
            // a source still waiting takes the bus first, then fast forward
            A_is_bus_forward_by_entry[i] = ~A_is_zero_by_entry[i] & ~A_ready_by_entry[i]
                & bus_match[i];
            A_is_fast_forward_by_entry[i] = ~A_is_zero_by_entry[i] & ~A_ready_by_entry[i]
                & ~bus_match[i] & ff_valid & (A_PR_by_entry[i] == ff_PR);
        end
    end

    assign issue_ready_by_entry = {IQ_ENTRIES{iss.ready}} & valid_by_entry
        & (A_is_zero_by_entry | A_ready_by_entry
           | A_is_bus_forward_by_entry | A_is_fast_forward_by_entry);

    // lowest ready entry, mask covers it and everything above
    always_comb begin
        logic found;
        found = 1'b0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            issue_one_hot[i] = issue_ready_by_entry[i] & ~found;
            found = found | issue_ready_by_entry[i];
            issue_mask[i] = found;
        end
    end

    always_comb begin
        iss.valid = |issue_ready_by_entry;
        iss.op = ADDI;
        iss.imm12 = '0;
        iss.A_PR = '0;
        iss.A_is_reg = 1'b0;
        iss.A_is_bus_forward = 1'b0;
        iss.A_is_fast_forward = 1'b0;
        iss.dest_PR = '0;
        iss.ROB_index = '0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (issue_one_hot[i]) begin
                iss.op = op_by_entry[i];
                iss.imm12 = imm12_by_entry[i];
                iss.A_PR = A_PR_by_entry[i];
                iss.A_is_reg = ~A_is_zero_by_entry[i] & A_ready_by_entry[i];
                iss.A_is_bus_forward = A_is_bus_forward_by_entry[i];
                iss.A_is_fast_forward = A_is_fast_forward_by_entry[i];
                iss.dest_PR = dest_PR_by_entry[i];
                iss.ROB_index = ROB_index_by_entry[i];
            end
        end
    end

    // ----------------------------------------------------------
    // enqueue into lowest free slot, collapse moves it down if needed

    always_comb begin
        logic taken;
        taken = 1'b0;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            enq_one_hot[i] = enq_valid & ~valid_by_entry[i] & ~taken;
            taken = taken | ~valid_by_entry[i];
        end
    end

    assign enq_ready = ~&valid_by_entry;

    // catch a producer that is on the bus during the enqueue cycle
    assign enq_bus_match = wb.valid_by_bank[enq_A_PR[LOG_PRF_BANK_COUNT-1:0]]
        && wb.upper_PR_by_bank[enq_A_PR[LOG_PRF_BANK_COUNT-1:0]]
           == enq_A_PR[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];

    // entry i takes entry i+1 at and above the issued slot
    always_ff @(posedge CLK or negedge nRST) begin
        int s;
        if (!nRST) begin
            valid_by_entry <= '0;
            A_ready_by_entry <= '0;
        end else begin
            for (int i = 0; i < IQ_ENTRIES; i++) begin
                s = i + int'(issue_mask[i]);
                if (s < IQ_ENTRIES && valid_by_entry[s]) begin
                    valid_by_entry[i] <= 1'b1;
                    A_ready_by_entry[i] <= A_ready_by_entry[s] | bus_match[s];
                end else begin
                    valid_by_entry[i] <= s < IQ_ENTRIES && enq_one_hot[s];
                    A_ready_by_entry[i] <= enq_A_ready | enq_bus_match;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        int s;
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            s = i + int'(issue_mask[i]);
            if (s < IQ_ENTRIES && valid_by_entry[s]) begin
                op_by_entry[i] <= op_by_entry[s];
                imm12_by_entry[i] <= imm12_by_entry[s];
                A_PR_by_entry[i] <= A_PR_by_entry[s];
                A_is_zero_by_entry[i] <= A_is_zero_by_entry[s];
                dest_PR_by_entry[i] <= dest_PR_by_entry[s];
                ROB_index_by_entry[i] <= ROB_index_by_entry[s];
            end else begin
                op_by_entry[i] <= enq_op;
                imm12_by_entry[i] <= enq_imm12;
                A_PR_by_entry[i] <= enq_A_PR;
                A_is_zero_by_entry[i] <= enq_A_is_zero;
                dest_PR_by_entry[i] <= enq_dest_PR;
                ROB_index_by_entry[i] <= enq_ROB_index;
            end
        end
    end

    // ----------------------------------------------------------
    // checks

    a_one_issue: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(issue_one_hot));

    // read stage relies on exactly one operand path
    a_src_excl: assert property (@(posedge CLK) disable iff (!nRST)
        iss.valid |-> $onehot0({iss.A_is_reg, iss.A_is_bus_forward, iss.A_is_fast_forward}));

endmodule

/* verilog/core_ifs.sv */
`timescale 1ns/1ps

// issue queue to operand read stage
interface issue_if import core_pkg::*; ();
    logic                       valid;
    logic                       ready;
    alu_op_t                    op;
    logic [11:0]                imm12;
    logic [LOG_PR_COUNT-1:0]    A_PR;
    logic                       A_is_reg;
    logic                       A_is_bus_forward;
    logic                       A_is_fast_forward;
    logic [LOG_PR_COUNT-1:0]    dest_PR;
    logic [LOG_ROB_ENTRIES-1:0] ROB_index;

    modport iq (
        output valid, op, imm12, A_PR, A_is_reg, A_is_bus_forward, A_is_fast_forward,
        output dest_PR, ROB_index,
        input  ready
    );
    modport rd (
        input  valid, op, imm12, A_PR, A_is_reg, A_is_bus_forward, A_is_fast_forward,
        input  dest_PR, ROB_index,
        output ready
    );
endinterface

// writeback bus, valid and register split by bank
interface wb_if import core_pkg::*; ();
    logic [PRF_BANK_COUNT-1:0]                                      valid_by_bank;
    logic [PRF_BANK_COUNT-1:0][LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_PR_by_bank;
    logic [XLEN-1:0]                                                data;
    logic [LOG_PR_COUNT-1:0]                                        dest_PR;
    logic [LOG_ROB_ENTRIES-1:0]                                     ROB_index;

    modport exec (output valid_by_bank, upper_PR_by_bank, data, dest_PR, ROB_index);
    modport iq (input valid_by_bank, upper_PR_by_bank);
    modport rd (input valid_by_bank, upper_PR_by_bank, data);
endinterface

/* verilog/core_pkg.sv */
package core_pkg;

    // ----------------------------------------------------------
    // sizes

    localparam int IQ_ENTRIES = 12;

    localparam int PR_COUNT = 32;
    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);

    // bank is the low bit of a register number
    localparam int PRF_BANK_COUNT = 2;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

    localparam int ROB_ENTRIES = 32;
    localparam int LOG_ROB_ENTRIES = $clog2(ROB_ENTRIES);

    localparam int XLEN = 32;

    // ----------------------------------------------------------
    // reg-imm opcodes, funct3 with bit 3 picking the arithmetic shift

    typedef enum logic [3:0] {
        ADDI  = 4'b0000,
        SLLI  = 4'b0001,
        SLTI  = 4'b0010,
        SLTIU = 4'b0011,
        XORI  = 4'b0100,
        SRLI  = 4'b0101,
        ORI   = 4'b0110,
        ANDI  = 4'b0111,
        SRAI  = 4'b1101
    } alu_op_t;

    // shared by RTL and testbench model
    function automatic logic [XLEN-1:0] alu_imm_result(
        input alu_op_t         op,
        input logic [XLEN-1:0] a,
        input logic [11:0]     imm12
    );
        logic [XLEN-1:0] imm;
        logic [4:0]      shamt;
        imm = {{(XLEN-12){imm12[11]}}, imm12};
        shamt = imm12[4:0];
        case (op)
            ADDI:    return a + imm;
            SLTI:    return XLEN'($signed(a) < $signed(imm));
            SLTIU:   return XLEN'(a < imm);
            XORI:    return a ^ imm;
            ORI:     return a | imm;
            ANDI:    return a & imm;
            SLLI:    return a << shamt;
            SRLI:    return a >> shamt;
            SRAI:    return $signed(a) >>> shamt;
            default: return '0;
        endcase
    endfunction

endpackage
